/* logic/i2c_defs.svh */
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// apb address width, byte offsets on word boundaries
`define I2C_APB_AW 5

// register map
`define I2C_REG_CTRL   5'h00
`define I2C_REG_ADDR   5'h04
`define I2C_REG_WDATA  5'h08
`define I2C_REG_DIV    5'h0c
`define I2C_REG_STATUS 5'h10
`define I2C_REG_RDATA  5'h14

// clock cycles per quarter of an scl period
// 125 gives 100 kHz scl from a 50 MHz clock
`define I2C_DIV_RESET 10'd125

// smaller divider writes are raised to this
`define I2C_DIV_MIN 10'd2

`endif

/* logic/i2c_pkg.sv */
package i2c_pkg;

    // direction bit sent after the device address
    typedef enum logic {
        I2C_WRITE = 1'b0,
        I2C_READ  = 1'b1
    } i2c_op;

    // register address width and data width
    typedef enum logic [1:0] {
        I2C_ADDR8_DATA8   = 2'd0,
        I2C_ADDR8_DATA16  = 2'd1,
        I2C_ADDR16_DATA8  = 2'd2,
        I2C_ADDR16_DATA16 = 2'd3
    } i2c_format;

    typedef enum logic {
        I2C_SUCCESS     = 1'b0,
        I2C_ACK_FAILURE = 1'b1
    } i2c_status;

    // bus engine sequence
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_REPEATED_START,
        ST_DEVICE_WRITE,
        ST_DEVICE_READ,
        ST_ADDR_MSB,
        ST_ADDR_LSB,
        ST_WDATA_MSB,
        ST_WDATA_LSB,
        ST_RDATA_MSB,
        ST_RDATA_LSB,
        ST_STOP
    } i2c_state;

endpackage

/* logic/i2c_regs.sv */
`timescale 1ns/1ns

`include "i2c_defs.svh"

module i2c_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`I2C_APB_AW-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   start,
    output i2c_pkg::i2c_op         op,
    output i2c_pkg::i2c_format     format,
    output logic [6:0]             device,
    output logic [15:0]            addr,
    output logic [15:0]            wdata,
    output logic [9:0]             div,
    input  logic                   busy,
    input  logic                   done,
    input  i2c_pkg::i2c_status     status,
    input  logic [15:0]            rdata
);
    import i2c_pkg::*;

    logic        access;
    logic        wr;
    logic        mapped;
    logic        locked;
    logic        go;
    logic        done_flag;
    logic        ack_fail;
    logic [15:0] rdata_q;

    // no wait states, every access phase completes
    assign access  = psel && penable;
    assign wr      = access && pwrite;
    assign pready  = access;
    assign pslverr = access && !mapped;

    // command is frozen from the go until the engine is idle again
    assign locked = busy || start;
    assign go     = wr && (paddr == `I2C_REG_CTRL) && pwdata[0] && !locked;

    // ctrl layout: [0] go, [1] op, [3:2] format, [14:8] device
    // status layout: [0] busy, [1] done, [2] ack_fail
    always_comb begin
        mapped = 1'b1;
        prdata = 32'd0;
        case (paddr)
            `I2C_REG_CTRL:   prdata = {17'd0, device, 4'd0, format, op, 1'b0};
            `I2C_REG_ADDR:   prdata = {16'd0, addr};
            `I2C_REG_WDATA:  prdata = {16'd0, wdata};
            `I2C_REG_DIV:    prdata = {22'd0, div};
            `I2C_REG_STATUS: prdata = {29'd0, ack_fail, done_flag, busy};
            `I2C_REG_RDATA:  prdata = {16'd0, rdata_q};
            default:         mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            div       <= `I2C_DIV_RESET;
            done_flag <= 1'b0;
            ack_fail  <= 1'b0;
        end else begin
            start <= go;
            if (wr && !locked && (paddr == `I2C_REG_DIV)) begin
                // too small a divider would leave no room inside a quarter
                if (pwdata[9:0] < `I2C_DIV_MIN) begin
                    div <= `I2C_DIV_MIN;
                end else begin
                    div <= pwdata[9:0];
                end
            end
            // result flags live until the next accepted go
            if (go) begin
                done_flag <= 1'b0;
                ack_fail  <= 1'b0;
            end else if (done) begin
                done_flag <= 1'b1;
                ack_fail  <= (status == I2C_ACK_FAILURE);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !locked) begin
            case (paddr)
                `I2C_REG_CTRL: begin
                    op     <= i2c_op'(pwdata[1]);
                    format <= i2c_format'(pwdata[3:2]);
                    device <= pwdata[14:8];
                end
                `I2C_REG_ADDR:  addr  <= pwdata[15:0];
                `I2C_REG_WDATA: wdata <= pwdata[15:0];
                default: ;
            endcase
        end
        if (done) begin
            rdata_q <= rdata;
        end
    end

endmodule

/* logic/i2c_phy.sv */
`timescale 1ns/1ns

module i2c_phy (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  i2c_pkg::i2c_op     op,
    input  i2c_pkg::i2c_format format,
    input  logic [6:0]         device,
    input  logic [15:0]        addr,
    input  logic [15:0]        wdata,
    input  logic [9:0]         div,
    output logic               busy,
    output logic               done,
    output i2c_pkg::i2c_status status,
    output logic [15:0]        rdata,
    input  logic               scl_in,
    input  logic               sda_in,
    output logic               scl_oe,
    output logic               sda_oe
);
    import i2c_pkg::*;

    i2c_state   state;
    i2c_state   state_next;
    logic [9:0] qcnt;
    logic [1:0] quarter;
    logic [3:0] bit_idx;
    logic [8:0] shift;
    logic       nack;
    logic       sda_drive;
    logic       scl_wait;
    logic       qtick;
    logic       sample;
    logic       slot_end;
    logic       slot_last;
    logic       ack_check;
    logic       rx_bit;
    logic       addr16;
    logic       data16;

    // byte plus the ninth (acknowledge) bit, msb first
    function automatic logic [8:0] load_byte(input i2c_state st);
        case (st)
            ST_DEVICE_WRITE: return {device, I2C_WRITE, 1'b1};
            ST_DEVICE_READ:  return {device, I2C_READ, 1'b1};
            ST_ADDR_MSB:     return {addr[15:8], 1'b1};
            ST_ADDR_LSB:     return {addr[7:0], 1'b1};
            ST_WDATA_MSB:    return {wdata[15:8], 1'b1};
            ST_WDATA_LSB:    return {wdata[7:0], 1'b1};
            // master acks the first byte of two, nacks the last
            ST_RDATA_MSB:    return {8'hff, 1'b0};
            default:         return 9'h1ff;
        endcase
    endfunction

    // 1 pulls sda low
    function automatic logic sda_level(input i2c_state st, input logic [1:0] q,
                                       input logic bit_out);
        case (st)
            ST_IDLE:           return 1'b0;
            // sda falls while scl is high
            ST_START,
            ST_REPEATED_START: return (q == 2'd3);
            // sda rises while scl is high
            ST_STOP:           return (q != 2'd3);
            default:           return !bit_out;
        endcase
    endfunction

    assign addr16 = (format == I2C_ADDR16_DATA8) || (format == I2C_ADDR16_DATA16);
    assign data16 = (format == I2C_ADDR8_DATA16) || (format == I2C_ADDR16_DATA16);

    // high time is counted from when scl is seen released
    assign scl_wait = (quarter == 2'd2) && !scl_in;
    assign qtick    = (qcnt == div - 10'd1) && !scl_wait;
    assign sample   = qtick && (quarter == 2'd2);
    assign slot_end = qtick && (quarter == 2'd3);

    assign slot_last = (state == ST_START) || (state == ST_REPEATED_START) ||
                       (state == ST_STOP) || (bit_idx == 4'd8);
    assign ack_check = (bit_idx == 4'd8) &&
                       ((state == ST_DEVICE_WRITE) || (state == ST_DEVICE_READ) ||
                        (state == ST_ADDR_MSB) || (state == ST_ADDR_LSB) ||
                        (state == ST_WDATA_MSB) || (state == ST_WDATA_LSB));
    assign rx_bit    = (bit_idx != 4'd8) &&
                       ((state == ST_RDATA_MSB) || (state == ST_RDATA_LSB));

    // state after the last slot of the current one, msb states skipped for 8-bit fields
    always_comb begin
        case (state)
            ST_START:          state_next = ST_DEVICE_WRITE;
            ST_DEVICE_WRITE:   state_next = addr16 ? ST_ADDR_MSB : ST_ADDR_LSB;
            ST_ADDR_MSB:       state_next = ST_ADDR_LSB;
            ST_ADDR_LSB: begin
                if (op == I2C_READ) begin
                    state_next = ST_REPEATED_START;
                end else begin
                    state_next = data16 ? ST_WDATA_MSB : ST_WDATA_LSB;
                end
            end
            ST_WDATA_MSB:      state_next = ST_WDATA_LSB;
            ST_REPEATED_START: state_next = ST_DEVICE_READ;
            ST_DEVICE_READ:    state_next = data16 ? ST_RDATA_MSB : ST_RDATA_LSB;
            ST_RDATA_MSB:      state_next = ST_RDATA_LSB;
            ST_STOP:           state_next = ST_IDLE;
            default:           state_next = ST_STOP;
        endcase
        // missing slave ack ends the transaction
        if (nack && (state != ST_STOP)) begin
            state_next = ST_STOP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            qcnt      <= 10'd0;
            quarter   <= 2'd0;
            bit_idx   <= 4'd0;
            busy      <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            sda_drive <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == ST_IDLE) begin
                qcnt      <= 10'd0;
                quarter   <= 2'd0;
                bit_idx   <= 4'd0;
                sda_drive <= 1'b0;
                if (start) begin
                    state <= ST_START;
                    busy  <= 1'b1;
                    nack  <= 1'b0;
                end
            end else begin
                // sda moves one clock after the quarter boundary, scl on it
                if (qcnt == 10'd0) begin
                    sda_drive <= sda_level(state, quarter, shift[8]);
                end
                if (scl_wait || qtick) begin
                    qcnt <= 10'd0;
                end else begin
                    qcnt <= qcnt + 10'd1;
                end
                if (qtick) begin
                    quarter <= quarter + 2'd1;
                end
                if (sample && ack_check && sda_in) begin
                    nack <= 1'b1;
                end
                if (slot_end) begin
                    if (slot_last) begin
                        state   <= state_next;
                        bit_idx <= 4'd0;
                        if (state == ST_STOP) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end
                    end else begin
                        bit_idx <= bit_idx + 4'd1;
                    end
                end
            end
        end
    end

    // shift register and read data
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && start) begin
            rdata <= 16'd0;
        end else if (sample && rx_bit) begin
            rdata <= {rdata[14:0], sda_in};
        end
        if (slot_end) begin
            shift <= slot_last ? load_byte(state_next) : {shift[7:0], 1'b1};
        end
    end

    assign status = nack ? I2C_ACK_FAILURE : I2C_SUCCESS;
    assign scl_oe = (state != ST_IDLE) && !quarter[1];
    assign sda_oe = sda_drive;

endmodule

/* logic/i2c_master.sv */
`timescale 1ns/1ns

`include "i2c_defs.svh"

module i2c_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`I2C_APB_AW-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   scl_in,
    input  logic                   sda_in,
    output logic                   scl_oe,
    output logic                   sda_oe
);
    import i2c_pkg::*;

    // command from the register block
    logic        start;
    i2c_op       op;
    i2c_format   format;
    logic [6:0]  device;
    logic [15:0] addr;
    logic [15:0] wdata;
    logic [9:0]  div;

    // result from the bus engine
    logic        busy;
    logic        done;
    i2c_status   status;
    logic [15:0] rdata;

    i2c_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .op      (op),
        .format  (format),
        .device  (device),
        .addr    (addr),
        .wdata   (wdata),
        .div     (div),
        .busy    (busy),
        .done    (done),
        .status  (status),
        .rdata   (rdata)
    );

    i2c_phy u_phy (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .format (format),
        .device (device),
        .addr   (addr),
        .wdata  (wdata),
        .div    (div),
        .busy   (busy),
        .done   (done),
        .status (status),
        .rdata  (rdata),
        .scl_in (scl_in),
        .sda_in (sda_in),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe)
    );

endmodule

/* tests/i2c_slave_model.sv */
`timescale 1ns/1ns

module i2c_slave_model #(
    parameter logic [6:0] DEVICE = 7'h50
) (
    input  logic scl,
    input  logic sda,
    input  logic addr16,
    output logic sda_oe
);
    logic [7:0]  mem [0:255];
    // received bytes, 9'h100 marks a repeated start
    logic [8:0]  log_mem [0:255];
    int          log_cnt;
    int          addr_left;
    logic        active;
    logic        expect_dev;
    logic        selected;
    logic        reading;
    logic        tx_active;
    logic        wait_mack;
    logic        send_next;
    logic [3:0]  bit_cnt;
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [15:0] ptr;

    task automatic log_byte(input logic [8:0] value);
        log_mem[log_cnt[7:0]] = value;
        log_cnt++;
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 7 + 3) ^ 8'h5a;
        end
        log_cnt    = 0;
        addr_left  = 0;
        active     = 1'b0;
        expect_dev = 1'b0;
        selected   = 1'b0;
        reading    = 1'b0;
        tx_active  = 1'b0;
        wait_mack  = 1'b0;
        send_next  = 1'b0;
        bit_cnt    = 4'd0;
        shreg      = 8'd0;
        tx         = 8'd0;
        ptr        = 16'd0;
        sda_oe     = 1'b0;
    end

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (selected) begin
                log_byte(9'h100);
            end
            active     = 1'b1;
            expect_dev = 1'b1;
            selected   = 1'b0;
            reading    = 1'b0;
            tx_active  = 1'b0;
            wait_mack  = 1'b0;
            send_next  = 1'b0;
            bit_cnt    = 4'd0;
            sda_oe     = 1'b0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active    = 1'b0;
            selected  = 1'b0;
            reading   = 1'b0;
            tx_active = 1'b0;
            sda_oe    = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bit_cnt < 4'd8) begin
                shreg = {shreg[6:0], sda};
            end else if (wait_mack) begin
                // master ack asks for another byte
                send_next = !sda;
                wait_mack = 1'b0;
            end
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    always @(negedge scl) begin
        if (active) begin
            if (bit_cnt == 4'd8) begin
                if (tx_active) begin
                    tx_active = 1'b0;
                    sda_oe    = 1'b0;
                    wait_mack = 1'b1;
                end else if (expect_dev) begin
                    expect_dev = 1'b0;
                    if (shreg[7:1] == DEVICE) begin
                        selected  = 1'b1;
                        reading   = shreg[0];
                        send_next = shreg[0];
                        if (!shreg[0]) begin
                            ptr       = 16'd0;
                            addr_left = addr16 ? 2 : 1;
                        end
                        log_byte({1'b0, shreg});
                        sda_oe = 1'b1;
                    end
                end else if (selected && !reading) begin
                    log_byte({1'b0, shreg});
                    if (addr_left == 2) begin
                        ptr = {shreg, 8'h00};
                    end else if (addr_left == 1) begin
                        ptr[7:0] = shreg;
                    end else begin
                        mem[ptr[7:0]] = shreg;
                        ptr = ptr + 16'd1;
                    end
                    if (addr_left > 0) begin
                        addr_left--;
                    end
                    sda_oe = 1'b1;
                end
            end else if (bit_cnt == 4'd9) begin
                bit_cnt = 4'd0;
                sda_oe  = 1'b0;
                if (selected && reading && send_next) begin
                    tx        = mem[ptr[7:0]];
                    ptr       = ptr + 16'd1;
                    tx_active = 1'b1;
                    send_next = 1'b0;
                    sda_oe    = !tx[7];
                end
            end else if (tx_active && (bit_cnt != 4'd0)) begin
                sda_oe = !tx[3'(7 - bit_cnt)];
            end
        end
    end

endmodule

/* tests/i2c_master_tb.sv */
`timescale 1ns/1ns

`include "i2c_defs.svh"

module i2c_master_tb;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`I2C_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   scl_oe;
    logic                   sda_oe;
    logic                   slave_sda_oe;
    logic                   slave_addr16;
    wire                    scl_line;
    wire                    sda_line;

    int          errors;
    int          test_count;
    logic [31:0] rng;
    logic [31:0] rd_val;
    logic        last_err;

    // open drain lines float high unless pulled
    assign scl_line = !scl_oe;
    assign sda_line = !(sda_oe || slave_sda_oe);

    i2c_master u_i2c_master (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl_in  (scl_line),
        .sda_in  (sda_line),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe)
    );

    i2c_slave_model #(.DEVICE(7'h50)) u_slave (
        .scl    (scl_line),
        .sda    (sda_line),
        .addr16 (slave_addr16),
        .sda_oe (slave_sda_oe)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] fill_value(input logic [7:0] index);
        return 8'(index * 7 + 3) ^ 8'h5a;
    endfunction

    // ctrl word with the go bit set
    function automatic logic [31:0] make_ctrl(input logic [6:0] dev, input logic op,
                                              input logic [1:0] fmt);
        return {17'd0, dev, 4'd0, fmt, op, 1'b1};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [`I2C_APB_AW-1:0] a, input logic [31:0] d);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= a;
        pwdata  <= d;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        last_err = pslverr;
        check("pready", 32'(pready), 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [`I2C_APB_AW-1:0] a, output logic [31:0] d);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= a;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        d        = prdata;
        last_err = pslverr;
        check("pready", 32'(pready), 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        polls = 0;
        st    = 32'd0;
        while (!st[1] && (polls < 30000)) begin
            apb_read(`I2C_REG_STATUS, st);
            polls++;
        end
        if (!st[1]) begin
            $display("timeout: transaction never reported done");
            errors++;
        end
    endtask

    task automatic check_log(input int base, input int idx, input logic [8:0] exp);
        check($sformatf("slave log[%0d]", idx), 32'(u_slave.log_mem[8'(base + idx)]), 32'(exp));
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("%s: %0d mismatches", name, errors - errs_before);
    endtask

    task automatic reset_test();
        int e;
        e = errors;
        check("scl line", 32'(scl_line), 32'd1);
        check("sda line", 32'(sda_line), 32'd1);
        check("pready", 32'(pready), 32'd0);
        check("pslverr", 32'(pslverr), 32'd0);
        apb_read(`I2C_REG_STATUS, rd_val);
        check("status", rd_val, 32'd0);
        check("pslverr", 32'(last_err), 32'd0);
        apb_read(`I2C_REG_DIV, rd_val);
        check("div", rd_val, 32'(`I2C_DIV_RESET));
        apb_read(5'h18, rd_val);
        check("pslverr", 32'(last_err), 32'd1);
        check("unmapped prdata", rd_val, 32'd0);
        apb_write(5'h1c, 32'hffff_ffff);
        check("pslverr", 32'(last_err), 32'd1);
        report_test("reset_state", e);
    endtask

    task automatic write8_test();
        int e;
        int base;
        e    = errors;
        base = u_slave.log_cnt;
        slave_addr16 <= 1'b0;
        apb_write(`I2C_REG_DIV, 32'd10);
        apb_write(`I2C_REG_ADDR, 32'h3c);
        apb_write(`I2C_REG_WDATA, 32'ha5);
        apb_write(`I2C_REG_CTRL, make_ctrl(7'h50, 1'b0, 2'd0));
        wait_done();
        apb_read(`I2C_REG_STATUS, rd_val);
        check("status", rd_val, 32'h2);
        check("slave log count", 32'(u_slave.log_cnt - base), 32'd3);
        check_log(base, 0, 9'h0a0);
        check_log(base, 1, 9'h03c);
        check_log(base, 2, 9'h0a5);
        check("slave mem[3c]", 32'(u_slave.mem[8'h3c]), 32'ha5);
        report_test("write_a8_d8", e);
    endtask

    task automatic write16_test();
        int          e;
        int          base;
        logic [15:0] a;
        logic [15:0] d;
        e = errors;
        slave_addr16 <= 1'b1;
        for (int pass = 0; pass < 2; pass++) begin
            rng  = xorshift32(rng);
            // keep the low address byte clear of the read test locations
            a    = {rng[15:8], 2'b01, rng[5:0]};
            rng  = xorshift32(rng);
            d    = rng[15:0];
            base = u_slave.log_cnt;
            if (pass == 1) begin
                apb_write(`I2C_REG_DIV, 32'd0);
                apb_read(`I2C_REG_DIV, rd_val);
                check("div", rd_val, 32'(`I2C_DIV_MIN));
            end
            apb_write(`I2C_REG_ADDR, 32'(a));
            apb_write(`I2C_REG_WDATA, 32'(d));
            apb_write(`I2C_REG_CTRL, make_ctrl(7'h50, 1'b0, 2'd3));
            wait_done();
            apb_read(`I2C_REG_STATUS, rd_val);
            check("status", rd_val, 32'h2);
            check("slave log count", 32'(u_slave.log_cnt - base), 32'd5);
            check_log(base, 0, 9'h0a0);
            check_log(base, 1, {1'b0, a[15:8]});
            check_log(base, 2, {1'b0, a[7:0]});
            check_log(base, 3, {1'b0, d[15:8]});
            check_log(base, 4, {1'b0, d[7:0]});
        end
        apb_write(`I2C_REG_DIV, 32'd10);
        report_test("write_a16_d16", e);
    endtask

    task automatic read_test();
        int e;
        int base;
        e    = errors;
        base = u_slave.log_cnt;
        slave_addr16 <= 1'b1;
        apb_write(`I2C_REG_ADDR, 32'h0190);
        apb_write(`I2C_REG_CTRL, make_ctrl(7'h50, 1'b1, 2'd3));
        wait_done();
        apb_read(`I2C_REG_STATUS, rd_val);
        check("status", rd_val, 32'h2);
        apb_read(`I2C_REG_RDATA, rd_val);
        check("rdata", rd_val, {16'd0, fill_value(8'h90), fill_value(8'h91)});
        check("slave log count", 32'(u_slave.log_cnt - base), 32'd5);
        check_log(base, 3, 9'h100);
        check_log(base, 4, 9'h0a1);

        base = u_slave.log_cnt;
        slave_addr16 <= 1'b0;
        apb_write(`I2C_REG_ADDR, 32'h21);
        apb_write(`I2C_REG_CTRL, make_ctrl(7'h50, 1'b1, 2'd0));
        wait_done();
        apb_read(`I2C_REG_RDATA, rd_val);
        check("rdata", rd_val, {24'd0, fill_value(8'h21)});
        check("slave log count", 32'(u_slave.log_cnt - base), 32'd4);
        check_log(base, 2, 9'h100);
        check_log(base, 3, 9'h0a1);
        report_test("reads", e);
    endtask

    task automatic absent_test();
        int e;
        int base;
        e    = errors;
        base = u_slave.log_cnt;
        apb_write(`I2C_REG_CTRL, make_ctrl(7'h23, 1'b0, 2'd0));
        wait_done();
        apb_read(`I2C_REG_STATUS, rd_val);
        check("status", rd_val, 32'h6);
        check("slave log count", 32'(u_slave.log_cnt - base), 32'd0);
        report_test("absent_device", e);
    endtask

    task automatic busy_test();
        int e;
        int base;
        e    = errors;
        base = u_slave.log_cnt;
        slave_addr16 <= 1'b0;
        apb_write(`I2C_REG_ADDR, 32'h12);
        apb_write(`I2C_REG_WDATA, 32'h66);
        apb_write(`I2C_REG_CTRL, make_ctrl(7'h50, 1'b0, 2'd0));
        apb_write(`I2C_REG_ADDR, 32'h77);
        apb_write(`I2C_REG_CTRL, make_ctrl(7'h50, 1'b0, 2'd0));
        wait_done();
        apb_read(`I2C_REG_ADDR, rd_val);
        check("addr", rd_val, 32'h12);
        // idle long enough for a second transaction to show up
        repeat (300) @(posedge clk);
        apb_read(`I2C_REG_STATUS, rd_val);
        check("status", rd_val, 32'h2);
        check("slave log count", 32'(u_slave.log_cnt - base), 32'd3);
        check_log(base, 1, 9'h012);
        check_log(base, 2, 9'h066);
        report_test("busy_refusal", e);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = 32'd0;
        slave_addr16 = 1'b0;
        errors       = 0;
        test_count   = 0;
        rng          = 32'd59;
        last_err     = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        reset_test();
        write8_test();
        write16_test();
        read_test();
        absent_test();
        busy_test();

        $display("%0d tests run, %0d errors", test_count, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/i2c_pkg.sv
logic/i2c_regs.sv
logic/i2c_phy.sv
logic/i2c_master.sv
tests/i2c_slave_model.sv
tests/i2c_master_tb.sv

/* Makefile */
TOP = i2c_master_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "Test completed successfully" > /dev/null

build:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
